/* build.f */
hw/gsu_mmio_pkg.sv
hw/gsu_core_pkg.sv
hw/gsu_cache.sv
hw/gsu_pipe_ctrl.sv
hw/gsu_fetch.sv
hw/gsu_execute.sv
hw/gsu_regs.sv
hw/gsu_top.sv
test/gsu_tb_props.sv
test/gsu_tb.sv

/* hw/gsu_cache.sv */
`default_nettype none

module gsu_cache (
  input  wire logic                    CLK,
  input  wire logic                    go,
  input  gsu_core_pkg::cache_req_t     host_req,
  input  gsu_core_pkg::cache_addr_t    fetch_addr,
  output gsu_core_pkg::byte_t          rd_data
);

  import gsu_core_pkg::*;

  byte_t       mem [CACHE_BYTES];
  cache_addr_t addr;
  logic        we;

  // Fetch owns the port while running, and only reads
  assign addr = go ? fetch_addr : host_req.addr;
  assign we   = ~go & host_req.we;

  // Single port, one cycle read latency
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= host_req.wdata;
    end
    rd_data <= mem[addr];
  end

endmodule

`default_nettype wire

/* hw/gsu_core_pkg.sv */
`default_nettype none

package gsu_core_pkg;

  // ------------------------------
  // Data widths and geometry
  // ------------------------------
  typedef logic [15:0] word_t;
  typedef logic [7:0]  byte_t;

  localparam int CACHE_BYTES = 512;
  typedef logic [$clog2(CACHE_BYTES)-1:0] cache_addr_t;

  localparam int GPR_COUNT   = 16;
  localparam int R15         = 15;   // Program counter
  localparam int GSU_CLK_DIV = 4;    // Core clocks per coprocessor clock

  // Opcodes left in this core
  localparam byte_t OP_STOP = 8'h00;
  localparam byte_t OP_NOP  = 8'h01;

  // Single cache port request
  typedef struct packed {
    logic        we;
    cache_addr_t addr;
    byte_t       wdata;
  } cache_req_t;

  // ------------------------------
  // Pipeline FSM encodings
  // ------------------------------
  typedef enum logic [4:0] {
    FETCH_IDLE   = 5'b00001,
    FETCH_LOOKUP = 5'b00010,
    FETCH_HIT    = 5'b00100,
    FETCH_FILL   = 5'b01000,
    FETCH_WAIT   = 5'b10000
  } fetch_state_t;

  typedef enum logic [3:0] {
    EXE_IDLE    = 4'b0001,
    EXE_DECODE  = 4'b0010,
    EXE_EXECUTE = 4'b0100,
    EXE_WAIT    = 4'b1000
  } exe_state_t;

endpackage

`default_nettype wire

/* hw/gsu_execute.sv */
`default_nettype none

module gsu_execute (
  input  wire logic               CLK,
  input  wire logic               RST,
  input  wire logic               go,
  input  wire logic               clk_en,
  input  wire logic               advance,
  input  gsu_core_pkg::byte_t     fetch_byte,
  output logic                    ready,
  output logic                    stop
);

  import gsu_core_pkg::*;

  exe_state_t state;
  byte_t      op_buf [2];
  logic       ptr;
  logic       go_q;
  logic       go_rise;
  byte_t      exe_op;
  logic       stop_pend;

  assign go_rise = go & ~go_q;
  assign ready   = (state == EXE_WAIT) & go;
  // STOP retires on the advance that swaps it out
  assign stop    = advance & stop_pend;

  // ------------------------------
  // Execute FSM
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      state     <= EXE_IDLE;
      ptr       <= 1'b0;
      go_q      <= 1'b0;
      stop_pend <= 1'b0;
    end else begin
      go_q <= go;
      unique case (state)
        EXE_IDLE:    if (go && clk_en) state <= EXE_DECODE;
        EXE_DECODE:  state <= EXE_EXECUTE;
        EXE_EXECUTE: begin
          // Only STOP decoded, all else is NOP
          stop_pend <= exe_op == OP_STOP;
          state     <= EXE_WAIT;
        end
        EXE_WAIT: begin
          if (!go)          state <= EXE_IDLE;
          else if (advance) state <= EXE_DECODE;
        end
        default: state <= EXE_IDLE;
      endcase
      if (go_rise)      ptr <= 1'b0;
      else if (advance) ptr <= ~ptr;
    end
  end

  // Opcode buffer, fetch stays one byte ahead
  always_ff @(posedge CLK) begin
    if (go_rise) begin
      op_buf[0] <= OP_NOP;
      op_buf[1] <= OP_NOP;
    end else if (advance) begin
      op_buf[~ptr] <= fetch_byte;
    end
    if (state == EXE_DECODE) begin
      exe_op <= op_buf[ptr];
    end
  end

endmodule

`default_nettype wire

/* hw/gsu_fetch.sv */
`default_nettype none

module gsu_fetch (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire logic                    go,
  input  wire logic                    clk_en,
  input  wire logic                    advance,
  input  gsu_core_pkg::word_t          pc,
  output gsu_core_pkg::cache_addr_t    cache_addr,
  input  gsu_core_pkg::byte_t          cache_rd_data,
  output gsu_core_pkg::byte_t          fetch_byte,
  output logic                         wait_load,
  output logic [3:0]                   wait_count,
  output logic                         ready
);

  import gsu_core_pkg::*;

  fetch_state_t state;
  logic         hit;

  // Cache sits at 0, anything below its size hits
  assign hit        = pc < word_t'(CACHE_BYTES);
  assign cache_addr = cache_addr_t'(pc);
  // Not ready once GO drops, so no stray advance
  assign ready      = (state == FETCH_WAIT) & go;

  // ------------------------------
  // Lookup FSM
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      state     <= FETCH_IDLE;
      wait_load <= 1'b0;
    end else begin
      wait_load <= 1'b0;
      unique case (state)
        FETCH_IDLE: begin
          // Align to the coprocessor clock
          if (go && clk_en) state <= FETCH_LOOKUP;
        end
        FETCH_LOOKUP: begin
          wait_load <= 1'b1;
          state     <= hit ? FETCH_HIT : FETCH_FILL;
        end
        FETCH_HIT, FETCH_FILL: state <= FETCH_WAIT;
        FETCH_WAIT: begin
          if (!go)          state <= FETCH_IDLE;
          else if (advance) state <= FETCH_LOOKUP;
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // Fetched byte and miss penalty
  always_ff @(posedge CLK) begin
    if (state == FETCH_LOOKUP) begin
      wait_count <= hit ? 4'd0 : 4'd1;
    end
    if (state == FETCH_HIT) begin
      fetch_byte <= cache_rd_data;
    end
    if (state == FETCH_FILL) begin
      // No ROM path here, miss delivers a NOP
      fetch_byte <= OP_NOP;
    end
  end

endmodule

`default_nettype wire

/* hw/gsu_mmio_pkg.sv */
`default_nettype none

package gsu_mmio_pkg;

  // ------------------------------
  // Host request / response
  // ------------------------------
  // Offset inside the 1 KB register window
  typedef logic [9:0] host_addr_t;

  // One-cycle rd or wr strobe
  typedef struct packed {
    logic       rd;
    logic       wr;
    host_addr_t addr;
    logic [7:0] wdata;
  } host_req_t;

  // Valid for one cycle; drive low means open bus
  typedef struct packed {
    logic       valid;
    logic       drive;
    logic [7:0] data;
  } host_rsp_t;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam host_addr_t ADDR_GPR_TOP = 10'h01F;  // R0..R15, low byte on even
  localparam host_addr_t ADDR_SFR     = 10'h030;  // Low byte, high at +1
  localparam host_addr_t ADDR_PBR     = 10'h034;
  localparam host_addr_t ADDR_ROMBR   = 10'h035;
  localparam host_addr_t ADDR_VCR     = 10'h03B;
  localparam host_addr_t ADDR_RAMBR   = 10'h03C;
  localparam host_addr_t ADDR_CBR     = 10'h03E;  // Low byte, high at +1
  localparam host_addr_t CACHE_WIN_LO = 10'h100;
  localparam host_addr_t CACHE_WIN_HI = 10'h2FF;

  // Fixed values and SFR fields
  localparam logic [7:0]  VCR_VALUE   = 8'd4;
  localparam int          SFR_GO_BIT  = 5;
  // Host-writable SFR bits 15, 12..8, 6..1
  localparam logic [15:0] SFR_WR_MASK = 16'h9F7E;

endpackage

`default_nettype wire

/* hw/gsu_pipe_ctrl.sv */
`default_nettype none

module gsu_pipe_ctrl (
  input  wire logic       CLK,
  input  wire logic       RST,
  input  wire logic       fetch_wait_load,
  input  wire logic [3:0] fetch_wait,
  input  wire logic       fetch_ready,
  input  wire logic       exe_ready,
  output logic            clk_en,
  output logic            advance
);

  import gsu_core_pkg::*;

  logic [$clog2(GSU_CLK_DIV)-1:0] div_cnt;
  logic [3:0]                     wait_cnt;

  // Coprocessor clock, last phase of the divider
  assign clk_en = div_cnt == ($bits(div_cnt))'(GSU_CLK_DIV - 1);

  always_ff @(posedge CLK) begin
    if (RST) begin
      div_cnt  <= '0;
      wait_cnt <= '0;
    end else begin
      div_cnt <= clk_en ? '0 : div_cnt + 1'b1;
      // Load beats a pending decrement
      if (fetch_wait_load) begin
        wait_cnt <= fetch_wait;
      end else if (clk_en && wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 4'd1;
      end
    end
  end

  // Both stages parked and no cycles still owed
  assign advance = clk_en & fetch_ready & exe_ready & (wait_cnt == '0);

endmodule

`default_nettype wire

/* hw/gsu_regs.sv */
`default_nettype none

module gsu_regs (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  gsu_mmio_pkg::host_req_t      host_req,
  output gsu_mmio_pkg::host_rsp_t      host_rsp,
  output gsu_core_pkg::cache_req_t     cache_req,
  input  gsu_core_pkg::byte_t          cache_rd_data,
  input  wire logic                    advance,
  input  wire logic                    stop,
  output logic                         go,
  output gsu_core_pkg::word_t          pc
);

  import gsu_mmio_pkg::*;
  import gsu_core_pkg::*;

  host_req_t   req_r;
  word_t       gpr [GPR_COUNT];
  logic [15:0] sfr;
  byte_t       pbr;
  byte_t       gpr_lo_latch;
  logic        cache_rd_pend;

  // Decode of the registered request
  logic        is_gpr;
  logic        is_sfr;
  logic        is_cache;
  logic [3:0]  gpr_idx;
  logic        gpr_hi;
  logic        rd_drive;
  byte_t       rd_data;

  assign go = sfr[SFR_GO_BIT];
  assign pc = gpr[R15];

  // ------------------------------
  // Window decode
  // ------------------------------
  assign is_gpr   = req_r.addr <= ADDR_GPR_TOP;
  assign is_sfr   = req_r.addr[9:1] == ADDR_SFR[9:1];
  assign is_cache = (req_r.addr >= CACHE_WIN_LO) && (req_r.addr <= CACHE_WIN_HI);
  assign gpr_idx  = req_r.addr[4:1];
  assign gpr_hi   = req_r.addr[0];

  // Host cache port, window folded so 0x100 lands on byte 0
  always_comb begin
    cache_req.we    = req_r.wr & is_cache & ~go;
    cache_req.addr  = {~req_r.addr[8], req_r.addr[7:0]};
    cache_req.wdata = req_r.wdata;
  end

  // Register read mux
  always_comb begin
    rd_drive = 1'b0;
    rd_data  = '0;
    if (is_gpr) begin
      // GPRs hidden while running
      rd_drive = ~go;
      rd_data  = gpr_hi ? gpr[gpr_idx][15:8] : gpr[gpr_idx][7:0];
    end else begin
      case (req_r.addr)
        ADDR_SFR:         begin rd_drive = 1'b1; rd_data = sfr[7:0];  end
        ADDR_SFR + 10'd1: begin rd_drive = 1'b1; rd_data = sfr[15:8]; end
        ADDR_PBR:         begin rd_drive = ~go;  rd_data = pbr;       end
        ADDR_VCR:         begin rd_drive = 1'b1; rd_data = VCR_VALUE; end
        // Constant zero bases
        ADDR_ROMBR, ADDR_RAMBR, ADDR_CBR, ADDR_CBR + 10'd1: rd_drive = ~go;
        default:          rd_drive = 1'b0;
      endcase
    end
  end

  // ------------------------------
  // Register file and response
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      req_r         <= '0;
      host_rsp      <= '0;
      cache_rd_pend <= 1'b0;
      sfr           <= '0;
      pbr           <= '0;
      for (int i = 0; i < GPR_COUNT; i++) begin
        gpr[i] <= '0;
      end
    end else begin
      req_r          <= host_req;
      host_rsp.valid <= 1'b0;
      host_rsp.drive <= 1'b0;

      // Register reads answer now, cache reads one cycle later
      cache_rd_pend <= req_r.rd & is_cache;
      if (req_r.rd && !is_cache) begin
        host_rsp <= '{valid: 1'b1, drive: rd_drive, data: rd_data};
      end
      if (cache_rd_pend) begin
        host_rsp <= '{valid: 1'b1, drive: 1'b1, data: cache_rd_data};
      end

      // Pipeline side
      if (advance) begin
        gpr[R15] <= gpr[R15] + word_t'(1);
      end
      if (stop) begin
        sfr[SFR_GO_BIT] <= 1'b0;
      end

      // Host writes win over STOP in the same cycle
      if (req_r.wr) begin
        if (is_gpr && !go && gpr_hi) begin
          gpr[gpr_idx] <= {req_r.wdata, gpr_lo_latch};
          // Writing PC high byte starts the program
          if (gpr_idx == 4'(R15)) begin
            sfr[SFR_GO_BIT] <= 1'b1;
          end
        end
        if (is_sfr && !req_r.addr[0]) begin
          sfr[7:0] <= (req_r.wdata & SFR_WR_MASK[7:0]) | (sfr[7:0] & ~SFR_WR_MASK[7:0]);
        end
        if (is_sfr && req_r.addr[0]) begin
          sfr[15:8] <= (req_r.wdata & SFR_WR_MASK[15:8]) | (sfr[15:8] & ~SFR_WR_MASK[15:8]);
        end
        if (req_r.addr == ADDR_PBR && !go) begin
          pbr <= req_r.wdata;
        end
      end
    end
  end

  // Low byte waits here for the matching high byte
  always_ff @(posedge CLK) begin
    if (RST) begin
      gpr_lo_latch <= '0;
    end else if (req_r.wr && is_gpr && !go && !gpr_hi) begin
      gpr_lo_latch <= req_r.wdata;
    end
  end

endmodule

`default_nettype wire

/* hw/gsu_top.sv */
`default_nettype none

module gsu_top (
  input  wire logic                CLK,
  input  wire logic                RST,
  input  gsu_mmio_pkg::host_req_t  host_req,
  output gsu_mmio_pkg::host_rsp_t  host_rsp
);

  import gsu_core_pkg::*;

  // ------------------------------
  // Internal nets
  // ------------------------------
  cache_req_t  cache_req;
  byte_t       cache_rd_data;
  cache_addr_t fetch_addr;
  byte_t       fetch_byte;
  word_t       pc;
  logic        go;
  logic        stop;
  logic        clk_en;
  logic        advance;
  logic        fetch_wait_load;
  logic [3:0]  fetch_wait;
  logic        fetch_ready;
  logic        exe_ready;

  // Host window and register file
  gsu_regs i_gsu_regs (
    .CLK, .RST, .host_req, .host_rsp, .cache_req, .cache_rd_data,
    .advance, .stop, .go, .pc
  );

  gsu_cache i_gsu_cache (
    .CLK, .go, .host_req(cache_req), .fetch_addr, .rd_data(cache_rd_data)
  );

  // Clock enable and stage sync
  gsu_pipe_ctrl i_gsu_pipe_ctrl (
    .CLK, .RST, .fetch_wait_load, .fetch_wait, .fetch_ready, .exe_ready,
    .clk_en, .advance
  );

  gsu_fetch i_gsu_fetch (
    .CLK, .RST, .go, .clk_en, .advance, .pc,
    .cache_addr(fetch_addr), .cache_rd_data, .fetch_byte,
    .wait_load(fetch_wait_load), .wait_count(fetch_wait), .ready(fetch_ready)
  );

  gsu_execute i_gsu_execute (
    .CLK, .RST, .go, .clk_en, .advance, .fetch_byte, .ready(exe_ready), .stop
  );

endmodule

`default_nettype wire

/* test/gsu_tb.sv */
`default_nettype none

module gsu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import gsu_mmio_pkg::*;
  import gsu_core_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int SEED       = 86;
  localparam int GPR_OPS    = 60;
  localparam int CACHE_OPS  = 48;
  localparam int PROGS      = 4;
  localparam int MAX_PROG   = 20;   // Longest program, STOP included
  localparam int RSP_LIMIT  = 8;    // Cycles allowed for one read response
  localparam int RUN_CYCLES = 64 * GSU_CLK_DIV;
  // Past the cache end each byte costs two coprocessor clocks
  localparam int MISS_ADV   = RUN_CYCLES / (2 * GSU_CLK_DIV);
  localparam word_t MISS_PC_LO = word_t'(CACHE_BYTES + MISS_ADV - 4);
  localparam word_t MISS_PC_HI = word_t'(CACHE_BYTES + MISS_ADV + 4);
  localparam int REQ_COUNT  = 2 * GPR_OPS + 2 * CACHE_OPS + PROGS * (MAX_PROG + 40) + 120;
  // Requests x longest program x 4 coprocessor clocks, plus margin
  localparam longint WATCHDOG_NS =
    longint'(REQ_COUNT) * MAX_PROG * 4 * GSU_CLK_DIV * CLK_PERIOD + 20000;

  logic        CLK;
  logic        RST;
  host_req_t   host_req;
  host_rsp_t   host_rsp;

  // Reference model
  word_t       gpr_m [GPR_COUNT];
  byte_t       cache_m [CACHE_BYTES];
  logic [15:0] sfr_m;
  byte_t       pbr_m;
  byte_t       latch_m;
  logic [31:0] lcg_state = SEED;

  gsu_top i_gsu_top (.CLK, .RST, .host_req, .host_rsp);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // ------------------------------
  // Random numbers and address map
  // ------------------------------
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Upper half, low bits of an LCG repeat quickly
    return lcg_state[31:16];
  endfunction

  function automatic byte_t rand_nonzero();
    return byte_t'(1 + next_rand() % 255);
  endfunction

  // Window 0x100 holds byte 0, 0x200 holds byte 256
  function automatic cache_addr_t win_to_cache(host_addr_t a);
    return cache_addr_t'(a - CACHE_WIN_LO);
  endfunction

  function automatic host_addr_t cache_to_win(cache_addr_t c);
    return c[8] ? {2'b10, c[7:0]} : {2'b01, c[7:0]};
  endfunction

  // ------------------------------
  // Error reporting and compares
  // ------------------------------
  task automatic stop_run(string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_rsp(host_rsp_t got, host_rsp_t exp, string what);
    if (got.valid !== exp.valid || got.drive !== exp.drive ||
        (exp.drive && got.data !== exp.data)) begin
      stop_run($sformatf("FAILED at %0d ns: %s valid=%b drive=%b data=0x%02h, exp %b %b 0x%02h",
        $time, what, got.valid, got.drive, got.data, exp.valid, exp.drive, exp.data));
    end
  endtask

  task automatic check_word(word_t got, word_t exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at %0d ns: %s read 0x%04h, expected 0x%04h",
        $time, what, got, exp));
    end
  endtask

  // ------------------------------
  // Host bus access
  // ------------------------------
  task automatic host_write(host_addr_t addr, byte_t data);
    @(posedge CLK);
    host_req <= '{rd: 1'b0, wr: 1'b1, addr: addr, wdata: data};
    @(posedge CLK);
    host_req <= '0;
    // Quiet gap before the next request
    repeat (3) @(posedge CLK);
  endtask

  task automatic host_read(host_addr_t addr, output host_rsp_t rsp);
    int waited;
    waited = 0;
    @(posedge CLK);
    host_req <= '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: 8'h00};
    @(posedge CLK);
    host_req <= '0;
    @(negedge CLK);
    while (!host_rsp.valid) begin
      waited++;
      if (waited > RSP_LIMIT) begin
        stop_run($sformatf("No read response from offset 0x%03h", addr));
      end
      @(negedge CLK);
    end
    rsp = host_rsp;
  endtask

  task automatic expect_read(host_addr_t addr, logic drive, byte_t data, string what);
    host_rsp_t rsp;
    host_rsp_t exp;
    exp = '{valid: 1'b1, drive: drive, data: data};
    host_read(addr, rsp);
    check_rsp(rsp, exp, what);
  endtask

  task automatic read_gpr(int idx, output word_t w);
    host_rsp_t lo;
    host_rsp_t hi;
    host_read(host_addr_t'(2 * idx), lo);
    host_read(host_addr_t'(2 * idx + 1), hi);
    if (!lo.drive || !hi.drive) begin
      stop_run($sformatf("Read of R%0d left the bus undriven with GO low", idx));
    end
    w = {hi.data, lo.data};
  endtask

  // Low byte only fills the latch, high byte stores the pair
  task automatic write_gpr_byte(int idx, logic hi, byte_t data);
    host_write(host_addr_t'(2 * idx + hi), data);
    if (hi) begin
      gpr_m[idx] = {data, latch_m};
    end else begin
      latch_m = data;
    end
  endtask

  task automatic write_cache(cache_addr_t c, byte_t d);
    host_write(cache_to_win(c), d);
    cache_m[c] = d;
  endtask

  // PC high byte write sets GO
  task automatic start_at(word_t s);
    write_gpr_byte(R15, 1'b0, s[7:0]);
    write_gpr_byte(R15, 1'b1, s[15:8]);
    sfr_m[SFR_GO_BIT] = 1'b1;
  endtask

  task automatic wait_go_low(int limit);
    host_rsp_t rsp;
    int polls;
    polls = 0;
    do begin
      host_read(ADDR_SFR, rsp);
      if (!rsp.drive) begin
        stop_run("SFR read left the bus undriven");
      end
      polls++;
      if (polls > limit) begin
        stop_run("GO never cleared after the program start");
      end
    end while (rsp.data[SFR_GO_BIT]);
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_run("Timeout: the test sequence did not finish in time");
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main
    word_t      w;
    word_t      s;
    byte_t      d;
    host_addr_t a;
    host_addr_t written [$];
    int         idx;
    int         k;

    RST      = 1'b1;
    host_req = '0;
    sfr_m    = '0;
    pbr_m    = '0;
    latch_m  = '0;
    for (int i = 0; i < GPR_COUNT; i++) begin
      gpr_m[i] = '0;
    end
    repeat (10) @(posedge CLK);
    RST <= 1'b0;

    // Reset values
    expect_read(ADDR_SFR, 1'b1, 8'h00, "SFR low after reset");
    expect_read(ADDR_SFR + 10'd1, 1'b1, 8'h00, "SFR high after reset");
    expect_read(ADDR_VCR, 1'b1, 8'd4, "VCR");
    expect_read(ADDR_ROMBR, 1'b1, 8'h00, "ROMBR");
    expect_read(ADDR_RAMBR, 1'b1, 8'h00, "RAMBR");
    expect_read(ADDR_CBR, 1'b1, 8'h00, "CBR low");
    expect_read(ADDR_CBR + 10'd1, 1'b1, 8'h00, "CBR high");
    for (int i = 0; i < GPR_COUNT; i++) begin
      read_gpr(i, w);
      check_word(w, gpr_m[i], $sformatf("R%0d after reset", i));
    end

    // SFR high byte keeps only writable bits
    host_write(ADDR_SFR + 10'd1, 8'hFF);
    sfr_m[15:8] = SFR_WR_MASK[15:8];
    expect_read(ADDR_SFR + 10'd1, 1'b1, sfr_m[15:8], "SFR high masked");

    // Random GPR traffic, R15 left out
    for (int i = 0; i < GPR_OPS; i++) begin
      idx = next_rand() % 15;
      case (next_rand() % 3)
        0: write_gpr_byte(idx, 1'b0, byte_t'(next_rand()));
        1: write_gpr_byte(idx, 1'b1, byte_t'(next_rand()));
        default: begin
          read_gpr(idx, w);
          check_word(w, gpr_m[idx], $sformatf("R%0d", idx));
        end
      endcase
    end
    for (int i = 0; i < 15; i++) begin
      read_gpr(i, w);
      check_word(w, gpr_m[i], $sformatf("R%0d final", i));
    end
    pbr_m = byte_t'(next_rand());
    host_write(ADDR_PBR, pbr_m);
    expect_read(ADDR_PBR, 1'b1, pbr_m, "PBR");

    // Cache window with the fold
    for (int i = 0; i < CACHE_OPS; i++) begin
      a = CACHE_WIN_LO + host_addr_t'(next_rand() % CACHE_BYTES);
      d = byte_t'(next_rand());
      host_write(a, d);
      cache_m[win_to_cache(a)] = d;
      written.push_back(a);
    end
    foreach (written[i]) begin
      expect_read(written[i], 1'b1, cache_m[win_to_cache(written[i])],
        $sformatf("cache offset 0x%03h", written[i]));
    end
    expect_read(10'h3F0, 1'b0, 8'h00, "unmapped 0x3F0");
    expect_read(10'h020, 1'b0, 8'h00, "unmapped 0x020");

    // Programs that end on STOP
    for (int p = 0; p < PROGS; p++) begin
      s = word_t'(next_rand() % (CACHE_BYTES - 2 * MAX_PROG));
      k = s + 2 + next_rand() % (MAX_PROG - 2);
      for (int c = s; c < k; c++) begin
        write_cache(cache_addr_t'(c), rand_nonzero());
      end
      write_cache(cache_addr_t'(k), OP_STOP);
      start_at(s);
      expect_read(10'h000, 1'b0, 8'h00, "R0 while running");
      wait_go_low(MAX_PROG * 4);
      sfr_m[SFR_GO_BIT] = 1'b0;
      gpr_m[R15] = word_t'(k + 2);
      read_gpr(R15, w);
      check_word(w, gpr_m[R15], $sformatf("R15 after STOP at 0x%03h", k));
      expect_read(ADDR_SFR, 1'b1, sfr_m[7:0], "SFR low after STOP");
    end

    // Run off the cache end, host stops it
    s = word_t'(16'h1FC + next_rand() % 3);
    for (int c = s; c < CACHE_BYTES; c++) begin
      write_cache(cache_addr_t'(c), rand_nonzero());
    end
    start_at(s);
    expect_read(ADDR_PBR, 1'b0, 8'h00, "PBR while running");
    repeat (RUN_CYCLES) @(posedge CLK);
    host_write(ADDR_SFR, 8'h00);
    sfr_m[7:0] = sfr_m[7:0] & ~SFR_WR_MASK[7:0];
    expect_read(ADDR_SFR, 1'b1, sfr_m[7:0], "SFR low after host stop");
    read_gpr(R15, w);
    if (w < MISS_PC_LO || w > MISS_PC_HI) begin
      stop_run($sformatf("FAILED at %0d ns: R15 0x%04h outside 0x%04h..0x%04h after miss run",
        $time, w, MISS_PC_LO, MISS_PC_HI));
    end
    for (int i = 0; i < R15; i++) begin
      read_gpr(i, w);
      check_word(w, gpr_m[i], $sformatf("R%0d after host stop", i));
    end
    expect_read(ADDR_PBR, 1'b1, pbr_m, "PBR after host stop");

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/gsu_tb_props.sv */
`default_nettype none

module gsu_tb_props (
  input  wire logic               CLK,
  input  wire logic               RST,
  input  gsu_mmio_pkg::host_rsp_t host_rsp,
  input  wire logic               clk_en,
  input  wire logic               advance,
  input  wire logic               go
);

  timeunit 1ns;
  timeprecision 100ps;

  // One response beat per read
  a_rsp_single: assert property (@(posedge CLK) disable iff (RST)
    host_rsp.valid |=> !host_rsp.valid)
    else $error("host_rsp.valid high on two cycles in a row");

  // Coprocessor clock, one core cycle in four
  a_clk_en_div: assert property (@(posedge CLK) disable iff (RST)
    clk_en |=> !clk_en ##1 !clk_en ##1 !clk_en ##1 clk_en)
    else $error("clk_en not high exactly one cycle in four");

  // Pipeline moves at most once per coprocessor clock
  a_adv_spacing: assert property (@(posedge CLK) disable iff (RST)
    advance |=> !advance ##1 !advance ##1 !advance)
    else $error("advance repeated within one coprocessor clock");

  // Core comes out of reset stopped
  a_go_after_rst: assert property (@(posedge CLK)
    RST |=> !go)
    else $error("GO high in the cycle after reset");

endmodule

bind gsu_top gsu_tb_props i_gsu_tb_props (
  .CLK, .RST, .host_rsp, .clk_en, .advance, .go
);

`default_nettype wire
